// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tinker_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tinker_model.svh ====
// Instruction-set reference model, included inside the testbench module and stepped once per commit
`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

logic [7:0]            m_mem [16384];                     // 16 KB byte array
tinker_isa_pkg::word_t m_regs [32];
tinker_isa_pkg::word_t m_pc;

function automatic tinker_isa_pkg::word_t m_read(input tinker_isa_pkg::word_t addr);
    tinker_isa_pkg::word_t v;
    for (int i = 0; i < 8; i++) begin
        v[8*i +: 8] = m_mem[14'(addr + 64'(i))];         // Little endian, wraps at 16 KB
    end
    return v;
endfunction

task automatic m_store(input tinker_isa_pkg::word_t addr, input tinker_isa_pkg::word_t data);
    for (int i = 0; i < 8; i++) begin
        m_mem[14'(addr + 64'(i))] = data[8*i +: 8];
    end
endtask

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = '0;
    end
    m_regs[31] = tinker_mem_pkg::STACK_INIT;               // Stack pointer
    m_pc       = tinker_mem_pkg::RESET_PC;
endtask

// Expected retire record and next PC of the instruction at m_pc
task automatic model_predict(output tinker_mem_pkg::retire_t want,
                             output tinker_isa_pkg::word_t next);
    tinker_isa_pkg::word_t ins, lit, a, b, d, slot;
    logic [4:0]            op;
    ins  = m_read(m_pc);                                   // Low half is the fetch
    op   = ins[31:27];
    lit  = {{52{ins[11]}}, ins[11:0]};
    a    = m_regs[ins[21:17]];                             // rs
    b    = m_regs[ins[16:12]];                             // rt
    d    = m_regs[ins[26:22]];                             // rd
    slot = m_regs[31] - 64'd8;                             // Link slot
    want         = '0;
    want.pc      = m_pc;
    want.wb_addr = ins[26:22];
    next         = m_pc + 64'd4;
    // Logic and shifts, moves and load, arithmetic
    want.wb_en = op inside {[5'h00 : 5'h07], [5'h10 : 5'h12], [5'h18 : 5'h1d]};
    case (op)
        tinker_isa_pkg::OP_AND:    want.wb_data = a & b;
        tinker_isa_pkg::OP_OR:     want.wb_data = a | b;
        tinker_isa_pkg::OP_XOR:    want.wb_data = a ^ b;
        tinker_isa_pkg::OP_NOT:    want.wb_data = ~a;
        tinker_isa_pkg::OP_SHFTR:  want.wb_data = $signed(a) >>> b[5:0];
        tinker_isa_pkg::OP_SHFTRI: want.wb_data = $signed(a) >>> lit[5:0];
        tinker_isa_pkg::OP_SHFTL:  want.wb_data = a << b[5:0];
        tinker_isa_pkg::OP_SHFTLI: want.wb_data = a << lit[5:0];
        tinker_isa_pkg::OP_ADD:    want.wb_data = a + b;
        tinker_isa_pkg::OP_ADDI:   want.wb_data = a + lit;
        tinker_isa_pkg::OP_SUB:    want.wb_data = a - b;
        tinker_isa_pkg::OP_SUBI:   want.wb_data = a - lit;
        tinker_isa_pkg::OP_MUL:    want.wb_data = a * b;
        tinker_isa_pkg::OP_DIV: begin
            if (b != '0) begin
                want.wb_data = $signed(a) / $signed(b);   // Zero divisor leaves 0
            end
        end
        tinker_isa_pkg::OP_MOV_RR: want.wb_data = a;
        tinker_isa_pkg::OP_MOV_RL: want.wb_data = lit;
        tinker_isa_pkg::OP_LOAD:   want.wb_data = m_read(a + lit);
        tinker_isa_pkg::OP_STORE: begin
            want.st_en   = 1'b1;
            want.st_addr = d + lit;
            want.st_data = a;
        end
        tinker_isa_pkg::OP_BR:     next = d;
        tinker_isa_pkg::OP_BRR_RD: next = m_pc + d;
        tinker_isa_pkg::OP_BRR_L:  next = m_pc + lit;
        tinker_isa_pkg::OP_BRNZ:   next = (a != '0) ? d : next;
        tinker_isa_pkg::OP_BRGT:   next = ($signed(a) > $signed(b)) ? d : next;
        tinker_isa_pkg::OP_CALL: begin
            want.st_en   = 1'b1;
            want.st_addr = slot;
            want.st_data = m_pc + 64'd4;                   // Push return address
            next         = d;
        end
        tinker_isa_pkg::OP_RET:    next = m_read(slot);
        default: begin
        end
    endcase
endtask

task automatic model_commit(input tinker_mem_pkg::retire_t want,
                            input tinker_isa_pkg::word_t next);
    if (want.wb_en && want.wb_addr != 5'd0) begin
        m_regs[want.wb_addr] = want.wb_data;               // R0 hardwired
    end
    if (want.st_en) begin
        m_store(want.st_addr, want.st_data);
    end
    m_pc = next;
endtask

`endif

// ==== bench/tinker_tb.sv ====
// Testbench for the core: loads memory in reset, runs LFSR-built code, checks retire per cycle
module tinker_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                    clk;
    logic                    reset;
    logic                    load_en;
    tinker_isa_pkg::word_t   load_addr;
    tinker_isa_pkg::word_t   load_data;
    tinker_mem_pkg::retire_t retire;

    logic [31:0] lfsr;
    logic [31:0] prog [$];                                 // Program from 0x2000
    int          error_count;
    int          cycle_count;

    `include "tinker_model.svh"

    tinker_core dut (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};                     // One step per bit
        end
    endtask

    task automatic emit(input logic [4:0] op, input int rd, input int rs, input int rt,
                        input int lit);
        prog.push_back({op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)});
    endtask

    // Absolute address of program slot index into register r
    task automatic set_target(input int r, input int index);
        emit(tinker_isa_pkg::OP_MOV_RL, r, 0, 0, 1);
        emit(tinker_isa_pkg::OP_SHFTLI, r, r, 0, 13);      // 0x2000
        emit(tinker_isa_pkg::OP_ADDI, r, r, 0, 4 * index);
    endtask

    task automatic random_instruction();
        logic [31:0] op, rd, rs, rt, lit;
        do begin
            take_bits(5, op);
        end while (!(op[4:0] inside {[5'h00 : 5'h0e], [5'h10 : 5'h13], [5'h18 : 5'h1d]}));
        take_bits(4, rd);                                  // r0..r15, keeps r21 r24 r31
        take_bits(5, rs);
        take_bits(5, rt);
        take_bits(12, lit);
        case (op[4:0])
            tinker_isa_pkg::OP_STORE:  rd = 32'd31;        // Stack area base
            tinker_isa_pkg::OP_LOAD:   rs = 32'd31;
            tinker_isa_pkg::OP_BRR_RD: rd = 32'd21;        // Holds 8
            tinker_isa_pkg::OP_BRR_L:  lit = 32'(lit[1:0]) * 32'd4 + 32'd4;
            tinker_isa_pkg::OP_BR, tinker_isa_pkg::OP_BRNZ,
            tinker_isa_pkg::OP_BRGT, tinker_isa_pkg::OP_CALL: rd = 32'd24;
            default: begin
            end
        endcase
        emit(op[4:0], int'(rd), int'(rs), int'(rt), int'(lit));
    endtask

    task automatic build_program();
        emit(tinker_isa_pkg::OP_MOV_RR, 1, 31, 0, 0);      // Stack top into r1
        emit(tinker_isa_pkg::OP_MOV_RL, 2, 0, 0, -5);
        emit(tinker_isa_pkg::OP_MOV_RL, 3, 0, 0, 7);
        emit(tinker_isa_pkg::OP_SUBI, 4, 2, 0, 100);
        emit(tinker_isa_pkg::OP_DIV, 5, 3, 2, 0);          // 7 / -5
        emit(tinker_isa_pkg::OP_DIV, 6, 3, 0, 0);          // Divide by zero
        emit(tinker_isa_pkg::OP_SHFTR, 7, 2, 3, 0);
        emit(tinker_isa_pkg::OP_STORE, 31, 2, 0, -64);
        emit(tinker_isa_pkg::OP_LOAD, 8, 31, 0, -64);      // Reads back r2
        emit(tinker_isa_pkg::OP_ADDI, 0, 3, 0, 5);         // R0 write
        emit(tinker_isa_pkg::OP_MOV_RR, 9, 0, 0, 0);
        emit(5'h14, 10, 2, 3, 0);                          // Former float code
        emit(5'h1f, 10, 2, 3, 0);
        set_target(20, prog.size() + 5);
        emit(tinker_isa_pkg::OP_BR, 20, 0, 0, 0);
        emit(tinker_isa_pkg::OP_MOV_RL, 10, 0, 0, 1);      // Skipped
        emit(tinker_isa_pkg::OP_MOV_RL, 21, 0, 0, 8);
        emit(tinker_isa_pkg::OP_BRR_RD, 21, 0, 0, 0);
        emit(tinker_isa_pkg::OP_MOV_RL, 10, 0, 0, 2);      // Skipped
        emit(tinker_isa_pkg::OP_BRR_L, 0, 0, 0, 8);
        emit(tinker_isa_pkg::OP_MOV_RL, 10, 0, 0, 3);      // Skipped
        set_target(20, prog.size() + 5);
        emit(tinker_isa_pkg::OP_BRNZ, 20, 3, 0, 0);
        emit(tinker_isa_pkg::OP_MOV_RL, 10, 0, 0, 4);      // Skipped
        emit(tinker_isa_pkg::OP_BRNZ, 20, 0, 0, 0);        // Not taken
        set_target(20, prog.size() + 5);
        emit(tinker_isa_pkg::OP_BRGT, 20, 3, 2, 0);        // 7 > -5
        emit(tinker_isa_pkg::OP_MOV_RL, 10, 0, 0, 5);      // Skipped
        emit(tinker_isa_pkg::OP_BRGT, 20, 2, 3, 0);        // Signed, not taken
        set_target(22, prog.size() + 5);
        emit(tinker_isa_pkg::OP_CALL, 22, 0, 0, 0);
        emit(tinker_isa_pkg::OP_BRR_L, 0, 0, 0, 12);       // Return lands here
        emit(tinker_isa_pkg::OP_ADDI, 11, 11, 0, 1);       // Subroutine body
        emit(tinker_isa_pkg::OP_RET, 0, 0, 0, 0);
        set_target(24, prog.size() + 103);                 // Middle of random block
        for (int i = 0; i < 200; i++) begin
            random_instruction();
        end
        if (prog.size() % 2 != 0) begin
            emit(tinker_isa_pkg::OP_AND, 0, 0, 0, 0);      // Pad to whole words
        end
    endtask

    // Program words at 0x2000, elsewhere a pattern of the word address
    function automatic tinker_isa_pkg::word_t mem_word(input int w);
        int idx;
        idx = 2 * (w - 1024);
        if (idx >= 0 && idx < prog.size()) begin
            return {prog[idx+1], prog[idx]};
        end
        return {32'(w) * 32'h9e37_79b9, ~32'(w) ^ 32'h5bd1_e995};
    endfunction

    task automatic check(input string name, input tinker_isa_pkg::word_t got,
                         input tinker_isa_pkg::word_t want);
        if (got !== want) begin
            error_count++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, want);
            $display("Done: errors found");
            $fatal(1, "mismatch in cycle %0d", cycle_count);
        end
    endtask

    initial begin
        tinker_mem_pkg::retire_t want;
        tinker_isa_pkg::word_t   next;
        reset       = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        error_count = 0;
        cycle_count = 0;
        lfsr        = 32'd99467;
        build_program();
        model_reset();
        for (int w = 0; w < 2048; w++) begin
            @(posedge clk);
            #2;
            load_en   = 1'b1;
            load_addr = 64'(8 * w);
            load_data = mem_word(w);
            m_store(load_addr, load_data);                 // Model mirrors the load
        end
        @(posedge clk);
        #2 load_en = 1'b0;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        for (cycle_count = 0; cycle_count < 400; cycle_count++) begin
            @(negedge clk);                                // Retire settled mid cycle
            model_predict(want, next);
            check("retire.pc", retire.pc, want.pc);
            check("retire.wb_en", 64'(retire.wb_en), 64'(want.wb_en));
            check("retire.st_en", 64'(retire.st_en), 64'(want.st_en));
            if (want.wb_en) begin
                check("retire.wb_addr", 64'(retire.wb_addr), 64'(want.wb_addr));
                check("retire.wb_data", retire.wb_data, want.wb_data);
            end
            if (want.st_en) begin
                check("retire.st_addr", retire.st_addr, want.st_addr);
                check("retire.st_data", retire.st_data, want.st_data);
            end
            model_commit(want, next);
        end
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

    // Watchdog for the whole run
    initial begin
        for (int n = 0; n < 3000; n++) begin
            @(posedge clk);
        end
        $display("Done: errors found");
        $fatal(1, "timeout, the run did not finish within 3000 clock cycles");
    end

endmodule

// ==== project.f ====
+incdir+bench
src/tinker_isa_pkg.sv
src/tinker_mem_pkg.sv
src/tinker_decoder.sv
src/tinker_regfile.sv
src/tinker_alu.sv
src/tinker_next_pc.sv
src/tinker_mem_access.sv
src/tinker_memory.sv
src/tinker_core.sv
bench/tinker_tb.sv

// ==== src/tinker_alu.sv ====
// Integer ALU: arithmetic, signed divide, shifts and bitwise logic on 64-bit operands
module tinker_alu (
    input  tinker_isa_pkg::word_t   a,
    input  tinker_isa_pkg::word_t   b,
    input  tinker_isa_pkg::alu_op_t op,
    output tinker_isa_pkg::word_t   result
);

    always_comb begin
        case (op)
            tinker_isa_pkg::ALU_ADD: result = a + b;
            tinker_isa_pkg::ALU_SUB: result = a - b;
            tinker_isa_pkg::ALU_MUL: result = a * b;                 // Low 64 bits
            tinker_isa_pkg::ALU_DIV: begin
                if (b == '0) begin
                    result = '0;                                     // Divide by zero
                end else begin
                    result = tinker_isa_pkg::word_t'($signed(a) / $signed(b));
                end
            end
            tinker_isa_pkg::ALU_SHR: result = $signed(a) >>> b[5:0]; // Sign fill
            tinker_isa_pkg::ALU_SHL: result = a << b[5:0];
            tinker_isa_pkg::ALU_AND: result = a & b;
            tinker_isa_pkg::ALU_OR:  result = a | b;
            tinker_isa_pkg::ALU_XOR: result = a ^ b;
            tinker_isa_pkg::ALU_NOT: result = ~a;                    // b ignored
            default:                 result = '0;
        endcase
    end

endmodule

// ==== src/tinker_core.sv ====
// Single-cycle core top level: PC register, operand and write-back muxes, retire record
module tinker_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_en,     // Program load, reset only
    input  tinker_isa_pkg::word_t   load_addr,
    input  tinker_isa_pkg::word_t   load_data,
    output tinker_mem_pkg::retire_t retire       // Instruction at current PC
);

    tinker_isa_pkg::word_t pc;
    tinker_isa_pkg::word_t next_pc;
    tinker_isa_pkg::word_t literal_ext;
    tinker_isa_pkg::word_t operand_b;
    tinker_isa_pkg::word_t alu_result;
    tinker_isa_pkg::word_t wb_data;
    tinker_isa_pkg::word_t mem_rdata;
    tinker_isa_pkg::word_t rs_data;
    tinker_isa_pkg::word_t rt_data;
    tinker_isa_pkg::word_t rd_data;
    tinker_isa_pkg::word_t sp_data;

    logic [tinker_isa_pkg::ILEN-1:0] instruction;
    tinker_isa_pkg::decoded_t        dec;
    tinker_mem_pkg::mem_req_t        req;
    tinker_mem_pkg::mem_req_t        mem_req;
    logic                            reg_we;
    logic                            is_transfer;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= tinker_mem_pkg::RESET_PC;
        end else begin
            pc <= next_pc;                       // One commit per edge
        end
    end

    assign literal_ext = {{(tinker_isa_pkg::XLEN - tinker_isa_pkg::LIT_BITS)
                           {dec.literal[tinker_isa_pkg::LIT_BITS-1]}}, dec.literal};
    assign operand_b   = dec.is_immediate ? literal_ext : rt_data;
    assign wb_data     = dec.use_mem_data ? mem_rdata : alu_result;
    assign reg_we      = dec.reg_write & ~reset; // No commit in reset

    always_comb begin
        mem_req    = req;
        mem_req.we = req.we & ~reset;            // Keeps the load port alone
    end

    always_comb begin
        retire         = '0;
        retire.pc      = pc;
        retire.wb_en   = dec.reg_write;
        retire.wb_addr = dec.rd;
        retire.wb_data = wb_data;
        retire.st_en   = req.we;
        retire.st_addr = req.addr;
        retire.st_data = req.wdata;
    end

    tinker_memory u_memory (
        .clk(clk), .pc(pc), .instruction(instruction), .req(mem_req), .rdata(mem_rdata),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    tinker_decoder u_decoder (.instruction(instruction), .dec(dec));

    tinker_regfile u_regfile (
        .clk(clk), .reset(reset), .rs_addr(dec.rs), .rt_addr(dec.rt), .rd_addr(dec.rd),
        .we(reg_we), .wdata(wb_data), .rs_data(rs_data), .rt_data(rt_data),
        .rd_data(rd_data), .sp_data(sp_data)
    );

    tinker_alu u_alu (.a(rs_data), .b(operand_b), .op(dec.alu_op), .result(alu_result));

    tinker_mem_access u_mem_access (
        .opcode(dec.opcode), .rs_data(rs_data), .rd_data(rd_data), .sp_data(sp_data),
        .literal_ext(literal_ext), .pc(pc), .req(req)
    );

    tinker_next_pc u_next_pc (
        .opcode(dec.opcode), .pc(pc), .rd_data(rd_data), .rs_data(rs_data),
        .rt_data(rt_data), .literal_ext(literal_ext), .mem_rdata(mem_rdata),
        .next_pc(next_pc)
    );

    // Any branch, call or return may leave word alignment
    assign is_transfer = dec.opcode inside {[tinker_isa_pkg::OP_BR : tinker_isa_pkg::OP_BRGT]};

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        ($past(pc[1:0]) == 2'b00 && !$past(is_transfer)) |-> pc[1:0] == 2'b00);

endmodule

// ==== src/tinker_decoder.sv ====
// Instruction decoder: splits the word into fields and derives ALU and write-back controls
module tinker_decoder (
    input  logic [tinker_isa_pkg::ILEN-1:0] instruction,
    output tinker_isa_pkg::decoded_t        dec
);

    always_comb begin
        dec              = '0;
        dec.opcode       = instruction[31:27];
        dec.rd           = instruction[26:22];
        dec.rs           = instruction[21:17];
        dec.rt           = instruction[16:12];
        dec.literal      = instruction[11:0];
        dec.alu_op       = tinker_isa_pkg::ALU_ADD;   // Moves and load ride on add
        dec.reg_write    = 1'b1;

        case (dec.opcode)
            tinker_isa_pkg::OP_AND:    dec.alu_op = tinker_isa_pkg::ALU_AND;
            tinker_isa_pkg::OP_OR:     dec.alu_op = tinker_isa_pkg::ALU_OR;
            tinker_isa_pkg::OP_XOR:    dec.alu_op = tinker_isa_pkg::ALU_XOR;
            tinker_isa_pkg::OP_NOT:    dec.alu_op = tinker_isa_pkg::ALU_NOT;
            tinker_isa_pkg::OP_SHFTR,
            tinker_isa_pkg::OP_SHFTRI: dec.alu_op = tinker_isa_pkg::ALU_SHR;
            tinker_isa_pkg::OP_SHFTL,
            tinker_isa_pkg::OP_SHFTLI: dec.alu_op = tinker_isa_pkg::ALU_SHL;
            tinker_isa_pkg::OP_ADD,
            tinker_isa_pkg::OP_ADDI:   dec.alu_op = tinker_isa_pkg::ALU_ADD;
            tinker_isa_pkg::OP_SUB,
            tinker_isa_pkg::OP_SUBI:   dec.alu_op = tinker_isa_pkg::ALU_SUB;
            tinker_isa_pkg::OP_MUL:    dec.alu_op = tinker_isa_pkg::ALU_MUL;
            tinker_isa_pkg::OP_DIV:    dec.alu_op = tinker_isa_pkg::ALU_DIV;
            tinker_isa_pkg::OP_MOV_RR: dec.rt = '0;   // rs + R0
            tinker_isa_pkg::OP_MOV_RL: dec.rs = '0;   // R0 + literal
            tinker_isa_pkg::OP_LOAD:   dec.use_mem_data = 1'b1;
            // Store, control flow, float and reserved codes write no register
            default:                   dec.reg_write = 1'b0;
        endcase

        dec.is_immediate = dec.opcode inside {
            tinker_isa_pkg::OP_ADDI, tinker_isa_pkg::OP_SUBI,
            tinker_isa_pkg::OP_SHFTRI, tinker_isa_pkg::OP_SHFTLI,
            tinker_isa_pkg::OP_MOV_RL
        };
    end

endmodule

// ==== src/tinker_isa_pkg.sv ====
// Instruction-set definitions (opcodes, ALU codes, field widths, decoded form) shared by the core
package tinker_isa_pkg;

    localparam int XLEN          = 64;                // Data path width
    localparam int ILEN          = 32;                // Instruction word width
    localparam int REG_ADDR_BITS = 5;                 // 32 architectural registers
    localparam int LIT_BITS      = 12;                // Signed literal field

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

    localparam reg_addr_t SP_REG = 5'd31;             // Stack pointer

    // Logic and shifts
    localparam logic [4:0] OP_AND    = 5'h00;
    localparam logic [4:0] OP_OR     = 5'h01;
    localparam logic [4:0] OP_XOR    = 5'h02;
    localparam logic [4:0] OP_NOT    = 5'h03;
    localparam logic [4:0] OP_SHFTR  = 5'h04;
    localparam logic [4:0] OP_SHFTRI = 5'h05;
    localparam logic [4:0] OP_SHFTL  = 5'h06;
    localparam logic [4:0] OP_SHFTLI = 5'h07;
    // Control flow, contiguous from BR to BRGT
    localparam logic [4:0] OP_BR     = 5'h08;
    localparam logic [4:0] OP_BRR_RD = 5'h09;
    localparam logic [4:0] OP_BRR_L  = 5'h0a;
    localparam logic [4:0] OP_BRNZ   = 5'h0b;
    localparam logic [4:0] OP_CALL   = 5'h0c;
    localparam logic [4:0] OP_RET    = 5'h0d;
    localparam logic [4:0] OP_BRGT   = 5'h0e;
    // Data movement
    localparam logic [4:0] OP_LOAD   = 5'h10;         // rd <- mem[rs + L]
    localparam logic [4:0] OP_MOV_RR = 5'h11;         // rd <- rs
    localparam logic [4:0] OP_MOV_RL = 5'h12;         // rd <- L
    localparam logic [4:0] OP_STORE  = 5'h13;         // mem[rd + L] <- rs
    // Integer arithmetic
    localparam logic [4:0] OP_ADD    = 5'h18;
    localparam logic [4:0] OP_ADDI   = 5'h19;
    localparam logic [4:0] OP_SUB    = 5'h1a;
    localparam logic [4:0] OP_SUBI   = 5'h1b;
    localparam logic [4:0] OP_MUL    = 5'h1c;
    localparam logic [4:0] OP_DIV    = 5'h1d;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_MUL = 4'd2,
        ALU_DIV = 4'd3,
        ALU_SHR = 4'd4,                               // Arithmetic
        ALU_SHL = 4'd5,
        ALU_AND = 4'd6,
        ALU_OR  = 4'd7,
        ALU_XOR = 4'd8,
        ALU_NOT = 4'd9
    } alu_op_t;

    typedef struct packed {
        logic [4:0]          opcode;
        reg_addr_t           rd;
        reg_addr_t           rs;
        reg_addr_t           rt;
        logic [LIT_BITS-1:0] literal;                 // Raw, extended in the core
        alu_op_t             alu_op;
        logic                is_immediate;            // Operand B from literal
        logic                reg_write;
        logic                use_mem_data;            // Write back load data
    } decoded_t;

endpackage

// ==== src/tinker_mem_access.sv ====
// Data memory request builder for load, store, call push and return pop
module tinker_mem_access (
    input  logic [4:0]               opcode,
    input  tinker_isa_pkg::word_t    rs_data,
    input  tinker_isa_pkg::word_t    rd_data,
    input  tinker_isa_pkg::word_t    sp_data,
    input  tinker_isa_pkg::word_t    literal_ext,
    input  tinker_isa_pkg::word_t    pc,
    output tinker_mem_pkg::mem_req_t req
);

    tinker_isa_pkg::word_t stack_slot;

    assign stack_slot = sp_data - 64'd8;                      // Return address slot

    always_comb begin
        req = '0;                                             // Idle, read at address 0
        case (opcode)
            tinker_isa_pkg::OP_LOAD: begin
                req.addr = rs_data + literal_ext;
            end
            tinker_isa_pkg::OP_STORE: begin
                req.addr  = rd_data + literal_ext;            // rd is the base here
                req.wdata = rs_data;
                req.we    = 1'b1;
            end
            tinker_isa_pkg::OP_CALL: begin
                req.addr  = stack_slot;
                req.wdata = pc + 64'd4;                       // Link value
                req.we    = 1'b1;
            end
            tinker_isa_pkg::OP_RET: begin
                req.addr = stack_slot;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== src/tinker_mem_pkg.sv ====
// Machine-level definitions (memory size, reset values, memory request and retire records)
package tinker_mem_pkg;

    localparam int MEM_ADDR_BITS = 14;                               // 16 KB byte array

    localparam tinker_isa_pkg::word_t RESET_PC   = 64'h2000;         // First fetch
    localparam tinker_isa_pkg::word_t STACK_INIT = 64'h3000;         // R31 after reset

    // Data port request, one per cycle
    typedef struct packed {
        tinker_isa_pkg::word_t addr;
        tinker_isa_pkg::word_t wdata;
        logic                  we;
    } mem_req_t;

    // What the next clock edge commits
    typedef struct packed {
        tinker_isa_pkg::word_t     pc;
        logic                      wb_en;
        tinker_isa_pkg::reg_addr_t wb_addr;
        tinker_isa_pkg::word_t     wb_data;
        logic                      st_en;                            // Store or call push
        tinker_isa_pkg::word_t     st_addr;
        tinker_isa_pkg::word_t     st_data;
    } retire_t;

endpackage

// ==== src/tinker_memory.sv ====
// Unified 16 KB little-endian byte memory with fetch, data and program load ports
module tinker_memory (
    input  logic                            clk,
    input  tinker_isa_pkg::word_t           pc,
    output logic [tinker_isa_pkg::ILEN-1:0] instruction,
    input  tinker_mem_pkg::mem_req_t        req,
    output tinker_isa_pkg::word_t           rdata,
    input  logic                            load_en,
    input  tinker_isa_pkg::word_t           load_addr,
    input  tinker_isa_pkg::word_t           load_data
);

    logic [7:0] mem [2**tinker_mem_pkg::MEM_ADDR_BITS];   // No clear, contents loaded

    logic                  wr_en;
    tinker_isa_pkg::word_t wr_addr;
    tinker_isa_pkg::word_t wr_data;

    // Byte index of base + offs, wrapping inside the array
    function automatic logic [tinker_mem_pkg::MEM_ADDR_BITS-1:0] byte_addr(
        input tinker_isa_pkg::word_t base,
        input int unsigned           offs
    );
        return base[tinker_mem_pkg::MEM_ADDR_BITS-1:0]
             + tinker_mem_pkg::MEM_ADDR_BITS'(offs);
    endfunction

    always_comb begin
        for (int unsigned i = 0; i < tinker_isa_pkg::ILEN / 8; i++) begin
            instruction[8*i +: 8] = mem[byte_addr(pc, i)];   // Fetch
        end
        for (int unsigned i = 0; i < tinker_isa_pkg::XLEN / 8; i++) begin
            rdata[8*i +: 8] = mem[byte_addr(req.addr, i)];   // Load and ret
        end
    end

    // Load port wins over the core
    assign wr_en   = load_en | req.we;
    assign wr_addr = load_en ? load_addr : req.addr;
    assign wr_data = load_en ? load_data : req.wdata;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int unsigned i = 0; i < tinker_isa_pkg::XLEN / 8; i++) begin
                mem[byte_addr(wr_addr, i)] <= wr_data[8*i +: 8];
            end
        end
    end

    // Program loading happens only while the core is held in reset
    a_load_excl: assert property (@(posedge clk) !(load_en && req.we));

endmodule

// ==== src/tinker_next_pc.sv ====
// Next-PC selection for branches, call and return; everything else falls through by 4
module tinker_next_pc (
    input  logic [4:0]            opcode,
    input  tinker_isa_pkg::word_t pc,
    input  tinker_isa_pkg::word_t rd_data,
    input  tinker_isa_pkg::word_t rs_data,
    input  tinker_isa_pkg::word_t rt_data,
    input  tinker_isa_pkg::word_t literal_ext,
    input  tinker_isa_pkg::word_t mem_rdata,   // Return address for ret
    output tinker_isa_pkg::word_t next_pc
);

    tinker_isa_pkg::word_t pc_plus4;

    assign pc_plus4 = pc + 64'd4;

    always_comb begin
        case (opcode)
            tinker_isa_pkg::OP_BR,
            tinker_isa_pkg::OP_CALL:   next_pc = rd_data;              // Absolute target
            tinker_isa_pkg::OP_BRR_RD: next_pc = pc + rd_data;
            tinker_isa_pkg::OP_BRR_L:  next_pc = pc + literal_ext;
            tinker_isa_pkg::OP_BRNZ:   next_pc = (rs_data != '0) ? rd_data : pc_plus4;
            tinker_isa_pkg::OP_BRGT: begin
                // Signed compare
                next_pc = ($signed(rs_data) > $signed(rt_data)) ? rd_data : pc_plus4;
            end
            tinker_isa_pkg::OP_RET:    next_pc = mem_rdata;            // Popped from stack
            default:                   next_pc = pc_plus4;
        endcase
    end

endmodule

// ==== src/tinker_regfile.sv ====
// Register file: 32 x 64 with four combinational reads, one write port and a fixed zero R0
module tinker_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  tinker_isa_pkg::reg_addr_t rs_addr,
    input  tinker_isa_pkg::reg_addr_t rt_addr,
    input  tinker_isa_pkg::reg_addr_t rd_addr,   // Read and write address
    input  logic                      we,
    input  tinker_isa_pkg::word_t     wdata,
    output tinker_isa_pkg::word_t     rs_data,
    output tinker_isa_pkg::word_t     rt_data,
    output tinker_isa_pkg::word_t     rd_data,
    output tinker_isa_pkg::word_t     sp_data    // Always R31
);

    tinker_isa_pkg::word_t regs [2**tinker_isa_pkg::REG_ADDR_BITS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**tinker_isa_pkg::REG_ADDR_BITS; i++) begin
                regs[i] <= '0;
            end
            regs[tinker_isa_pkg::SP_REG] <= tinker_mem_pkg::STACK_INIT;  // Stack top
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= wdata;                  // R0 stays zero
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign rd_data = regs[rd_addr];
    assign sp_data = regs[tinker_isa_pkg::SP_REG];

    // R0 holds across every commit, whatever the decoder asks for
    a_r0_stable: assert property (@(posedge clk) disable iff (reset) $stable(regs[0]));

endmodule
